//--- src.f
+incdir+rtl
rtl/ooo_types_pkg.sv
rtl/ooo_ctrl_pkg.sv
rtl/rob.sv
rtl/free_list.sv
rtl/map_table.sv
rtl/redirect_ctrl.sv
rtl/rename_core.sv
dv/tb_rename_core.sv

//--- Makefile
# Verilator build and run for the rename core testbench
VERILATOR ?= verilator
TOP       ?= tb_rename_core
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) rtl/ooo_settings.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG) || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_rename_core.sv
/*
 * testbench for the rename and retire core
 * applies a table of dispatch, completion, ack and idle rows and checks
 * the DUT every cycle against a model of map, free list and in-flight list
 */
`default_nettype none
`include "ooo_settings.svh"

module tb_rename_core;
	import ooo_types_pkg::*;

	typedef enum logic [1:0] {OP_DISP, OP_CMPL, OP_ACK, OP_IDLE} op_kind_t;
	typedef struct packed {
		op_kind_t	kind;
		logic [3:0]	arg;	// areg, queue position or idle cycles
		logic		br;
		logic		flag;	// predicted or actual direction
		br_tag_t	tag;
	} op_t;
	typedef struct packed {
		rob_idx_t	idx;
		areg_t		areg;
		preg_t		preg;
		preg_t		old;
		logic		br;
		logic		pred;
		br_tag_t	tag;
		logic		done;
	} ent_t;

	localparam int CLK_PERIOD = 100;
	localparam int RAND_POS = 15;	// completion entry taken from the LFSR

	logic		clk, rst, disp_valid, disp_br, disp_pred, cmpl_valid, cmpl_taken;
	logic		redirect_ack, disp_ready, retire_valid, redirect_req, redirect_taken;
	areg_t		disp_areg, retire_areg;
	br_tag_t	disp_tag;
	rob_idx_t	cmpl_idx, disp_rob_idx;
	preg_t		disp_preg, disp_old_preg, retire_preg;

	// ----------------------------------------
	// reference model state
	// ----------------------------------------
	preg_t		map_m [`OOO_AREG_NUM];
	preg_t		ckpt_m [`OOO_BR_NUM][`OOO_AREG_NUM];	// map per branch tag
	preg_t		free_q [$];
	ent_t		fly_q [$];	// in flight, oldest first
	rob_idx_t	tail_m;
	int		rd_state;	// 0 idle, 1 req, 2 wait for ack low
	logic		rd_taken;
	logic		fired;		// dispatch went through this cycle
	op_t		ops [$];
	logic		tbl_done;
	logic [31:0]	lfsr_q;

	rename_core u_rename_core (
		.clk, .rst,
		.disp_valid_i(disp_valid), .disp_areg_i(disp_areg), .disp_br_i(disp_br),
		.disp_pred_taken_i(disp_pred), .disp_br_tag_i(disp_tag),
		.cmpl_valid_i(cmpl_valid), .cmpl_rob_idx_i(cmpl_idx), .cmpl_taken_i(cmpl_taken),
		.redirect_ack_i(redirect_ack),
		.disp_ready_o(disp_ready), .disp_rob_idx_o(disp_rob_idx), .disp_preg_o(disp_preg),
		.disp_old_preg_o(disp_old_preg), .retire_valid_o(retire_valid),
		.retire_areg_o(retire_areg), .retire_preg_o(retire_preg),
		.redirect_req_o(redirect_req), .redirect_taken_o(redirect_taken)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_preg(input string name, input preg_t got, input preg_t exp);
		if (got !== exp)
			abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_areg(input string name, input areg_t got, input areg_t exp);
		if (got !== exp)
			abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_idx(input string name, input rob_idx_t got, input rob_idx_t exp);
		if (got !== exp)
			abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);	// one step per bit
			val = (val << 1) | int'(lfsr_q[0]);
		end
	endtask

	function automatic int find_pos(input rob_idx_t idx);
		foreach (fly_q[i])
			if (fly_q[i].idx == idx)
				return i;
		return -1;
	endfunction

	// ----------------------------------------
	// per-cycle compare, then model the edge
	// ----------------------------------------
	task automatic check_and_advance();
		ent_t	e, br_e;
		int	k, rd_next;
		logic	flush_exp, ready_exp, ret_exp;
		rd_next = rd_state;
		flush_exp = 1'b0;
		k = cmpl_valid ? find_pos(cmpl_idx) : 0;
		if (k < 0)
			abort_run("completion names a ROB slot that holds no instruction");
		else if (cmpl_valid)
			flush_exp = fly_q[k].br && (fly_q[k].pred != cmpl_taken);	// mispredict
		ready_exp = (fly_q.size() < `OOO_ROB_DEPTH) && (free_q.size() > 0)
			&& (rd_state == 0) && !flush_exp;
		ret_exp = (fly_q.size() > 0) && fly_q[0].done;
		check_bit("disp_ready_o", disp_ready, ready_exp);
		check_bit("retire_valid_o", retire_valid, ret_exp);
		check_bit("redirect_req_o", redirect_req, rd_state == 1);
		if (rd_state == 1)
			check_bit("redirect_taken_o", redirect_taken, rd_taken);
		fired = disp_valid && ready_exp;
		if (fired) begin
			check_idx("disp_rob_idx_o", disp_rob_idx, tail_m);
			if (!disp_br) begin
				check_preg("disp_preg_o", disp_preg, free_q[0]);
				check_preg("disp_old_preg_o", disp_old_preg, map_m[disp_areg]);
			end
		end
		if (ret_exp) begin
			e = fly_q.pop_front();
			check_areg("retire_areg_o", retire_areg, e.br ? areg_t'(0) : e.areg);
			check_preg("retire_preg_o", retire_preg, e.br ? preg_t'(0) : e.preg);
			if (!e.br)
				free_q.push_back(e.old);	// old mapping freed
		end
		if (cmpl_valid) begin
			k = find_pos(cmpl_idx);		// head may have just left
			br_e = fly_q[k];
			br_e.done = 1'b1;
			fly_q[k] = br_e;
			if (flush_exp) begin
				while (fly_q.size() > k + 1) begin
					e = fly_q.pop_back();
					if (!e.br)
						free_q.push_front(e.preg);	// back in allocation order
				end
				map_m = ckpt_m[br_e.tag];
				tail_m = br_e.idx + rob_idx_t'(1);
				rd_taken = cmpl_taken;
			end
		end
		case (rd_state)
			0: if (flush_exp) rd_next = 1;
			1: if (redirect_ack) rd_next = 2;
			default: if (!redirect_ack) rd_next = 0;
		endcase
		rd_state = rd_next;
		if (fired) begin
			e.idx = tail_m;
			e.areg = disp_areg;
			e.preg = disp_br ? preg_t'(0) : free_q.pop_front();
			e.old = map_m[disp_areg];
			e.br = disp_br;
			e.pred = disp_pred;
			e.tag = disp_tag;
			e.done = 1'b0;
			if (disp_br)
				ckpt_m[disp_tag] = map_m;
			else
				map_m[disp_areg] = e.preg;
			fly_q.push_back(e);
			tail_m = tail_m + rob_idx_t'(1);
		end
	endtask

	task automatic run_cycle();
		@(negedge clk);		// outputs settled
		check_and_advance();
		@(posedge clk);
		#1;
	endtask

	task automatic apply_row(input op_t r);
		int	cnt, pick;
		int	open_pos [$];
		pick = -1;
		case (r.kind)
			OP_DISP: begin
				disp_valid = 1'b1;
				disp_areg = areg_t'(r.arg);
				disp_br = r.br;
				disp_pred = r.flag;
				disp_tag = r.tag;
				fired = 1'b0;
				while (!fired)
					run_cycle();	// held until accepted
				disp_valid = 1'b0;
			end
			OP_CMPL: begin
				if (r.arg == 4'(RAND_POS)) begin
					foreach (fly_q[i])
						if (!fly_q[i].done)
							open_pos.push_back(i);
					if (open_pos.size() != 0) begin
						rand_bits(3, cnt);
						pick = open_pos[cnt % open_pos.size()];
					end
				end else if (int'(r.arg) < fly_q.size()) begin
					pick = int'(r.arg);
				end
				if (pick < 0) begin
					abort_run("completion row found no instruction to complete");
				end else begin
					cmpl_idx = fly_q[pick].idx;
					// random picks resolve as predicted
					cmpl_taken = (r.arg == 4'(RAND_POS)) ? fly_q[pick].pred : r.flag;
					cmpl_valid = 1'b1;
					run_cycle();
					cmpl_valid = 1'b0;
				end
			end
			OP_ACK: begin
				while (rd_state != 1)
					run_cycle();
				redirect_ack = 1'b1;
				while (rd_state == 1)
					run_cycle();
				redirect_ack = 1'b0;
				while (rd_state != 0)
					run_cycle();
			end
			default: begin
				rand_bits(2, cnt);	// extra gap 0..3
				repeat (int'(r.arg) + cnt)
					run_cycle();
			end
		endcase
	endtask

	task automatic add_row(input op_kind_t k, input int arg, input logic br,
			input logic flag, input int tag);
		op_t	r;
		r.kind = k;
		r.arg = 4'(arg);
		r.br = br;
		r.flag = flag;
		r.tag = br_tag_t'(tag);
		ops.push_back(r);
	endtask

	// ----------------------------------------
	// op table
	// ----------------------------------------
	task automatic build_table();
		for (int a = 0; a < 8; a++)
			add_row(OP_DISP, a, 1'b0, 1'b0, 0);	// fills ROB and free list
		add_row(OP_IDLE, 2, 1'b0, 1'b0, 0);		// ready must stay low
		for (int n = 0; n < 8; n++) begin
			add_row(OP_CMPL, RAND_POS, 1'b0, 1'b0, 0);
			add_row(OP_IDLE, 0, 1'b0, 1'b0, 0);
		end
		add_row(OP_IDLE, 10, 1'b0, 1'b0, 0);		// drain
		add_row(OP_DISP, 3, 1'b0, 1'b0, 0);
		add_row(OP_DISP, 5, 1'b0, 1'b0, 0);
		add_row(OP_DISP, 7, 1'b1, 1'b0, 1);		// branch, predicted not taken
		add_row(OP_DISP, 3, 1'b0, 1'b0, 0);
		add_row(OP_DISP, 6, 1'b0, 1'b0, 0);
		add_row(OP_CMPL, 2, 1'b0, 1'b1, 0);		// resolves taken, mispredict
		add_row(OP_ACK, 0, 1'b0, 1'b0, 0);
		add_row(OP_DISP, 3, 1'b0, 1'b0, 0);		// gets the squashed preg back
		add_row(OP_DISP, 5, 1'b1, 1'b1, 2);		// branch, predicted taken
		add_row(OP_DISP, 6, 1'b0, 1'b0, 0);
		add_row(OP_CMPL, 4, 1'b0, 1'b1, 0);		// correct, no redirect
		for (int n = 0; n < 4; n++) begin
			add_row(OP_CMPL, RAND_POS, 1'b0, 1'b0, 0);
			add_row(OP_IDLE, 1, 1'b0, 1'b0, 0);
		end
		add_row(OP_IDLE, 10, 1'b0, 1'b0, 0);
		// two branches among eight, ROB full while pregs remain
		for (int a = 0; a < 8; a++)
			add_row(OP_DISP, a, (a == 2 || a == 5), 1'b0, a % 4);
		add_row(OP_IDLE, 2, 1'b0, 1'b0, 0);		// ready held low by the ROB alone
		for (int n = 0; n < 8; n++) begin
			add_row(OP_CMPL, RAND_POS, 1'b0, 1'b0, 0);
			add_row(OP_IDLE, 0, 1'b0, 1'b0, 0);
		end
		add_row(OP_IDLE, 10, 1'b0, 1'b0, 0);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		disp_valid = 1'b0;
		disp_areg = '0;
		disp_br = 1'b0;
		disp_pred = 1'b0;
		disp_tag = '0;
		cmpl_valid = 1'b0;
		cmpl_idx = '0;
		cmpl_taken = 1'b0;
		redirect_ack = 1'b0;
		lfsr_q = 32'h89f;
		rd_state = 0;
		rd_taken = 1'b0;
		tail_m = '0;
		fired = 1'b0;
		for (int r = 0; r < `OOO_AREG_NUM; r++)
			map_m[r] = preg_t'(r);	// identity at reset
		for (int i = 0; i < `OOO_PREG_NUM - `OOO_AREG_NUM; i++)
			free_q.push_back(preg_t'(`OOO_AREG_NUM + i));
		build_table();
		tbl_done = 1'b1;
		repeat (5) @(posedge clk);
		#1 rst = 1'b0;
		foreach (ops[i])
			apply_row(ops[i]);
		$display("*** PASSED ***");
		$finish;
	end

	// watchdog, 20 cycles per table row
	initial begin
		wait (tbl_done === 1'b1);
		#(ops.size() * 20 * CLK_PERIOD);
		abort_run("watchdog expired before the op table was applied");
	end

endmodule

`default_nettype wire

//--- rtl/rename_core.sv
/*
 * rename and in-order retire core
 * ties ROB, free list, map table and redirect sequencer together
 * and forms dispatch ready
 */
`default_nettype none

module rename_core (
	input  wire logic			clk,
	input  wire logic			rst,
	input  wire logic			disp_valid_i,
	input  wire ooo_types_pkg::areg_t	disp_areg_i,
	input  wire logic			disp_br_i,
	input  wire logic			disp_pred_taken_i,
	input  wire ooo_types_pkg::br_tag_t	disp_br_tag_i,
	input  wire logic			cmpl_valid_i,
	input  wire ooo_types_pkg::rob_idx_t	cmpl_rob_idx_i,
	input  wire logic			cmpl_taken_i,
	input  wire logic			redirect_ack_i,
	output logic				disp_ready_o,
	output ooo_types_pkg::rob_idx_t		disp_rob_idx_o,
	output ooo_types_pkg::preg_t		disp_preg_o,
	output ooo_types_pkg::preg_t		disp_old_preg_o,
	output logic				retire_valid_o,
	output ooo_types_pkg::areg_t		retire_areg_o,
	output ooo_types_pkg::preg_t		retire_preg_o,
	output logic				redirect_req_o,
	output logic				redirect_taken_o
);
	import ooo_types_pkg::*;

	logic		disp_fire, alloc;
	logic		rob_full, fl_empty, redir_busy;
	preg_t		fl_head_preg, map_old_preg, ret_old_preg;
	fl_ptr_t	fl_head_ptr, flush_fl_head;
	br_tag_t	flush_br_tag;
	logic		ret_has_dest, rob_flush;

	// ----------------------------------------
	// dispatch control
	// ----------------------------------------
	assign disp_ready_o = !rob_full && !fl_empty && !redir_busy;
	assign disp_fire = disp_valid_i && disp_ready_o;
	assign alloc = disp_fire && !disp_br_i;	// only writers take a preg

	assign disp_preg_o = fl_head_preg;
	assign disp_old_preg_o = map_old_preg;

	rob u_rob (
		.clk, .rst,
		.disp_fire_i(disp_fire), .disp_areg_i, .disp_preg_i(fl_head_preg),
		.disp_old_preg_i(map_old_preg), .disp_br_i, .disp_pred_taken_i,
		.disp_br_tag_i, .disp_fl_head_i(fl_head_ptr),
		.cmpl_valid_i, .cmpl_rob_idx_i, .cmpl_taken_i,
		.full_o(rob_full), .tail_idx_o(disp_rob_idx_o),
		.retire_valid_o, .retire_areg_o, .retire_preg_o,
		.retire_old_preg_o(ret_old_preg), .retire_has_dest_o(ret_has_dest),
		.flush_o(rob_flush), .flush_fl_head_o(flush_fl_head),
		.flush_br_tag_o(flush_br_tag)
	);

	free_list u_free_list (
		.clk, .rst,
		.alloc_i(alloc),
		.free_valid_i(retire_valid_o && ret_has_dest),	// old mapping comes back
		.free_preg_i(ret_old_preg),
		.restore_i(rob_flush), .restore_head_i(flush_fl_head),
		.empty_o(fl_empty), .head_preg_o(fl_head_preg), .head_ptr_o(fl_head_ptr)
	);

	map_table u_map_table (
		.clk, .rst,
		.rd_areg_i(disp_areg_i),
		.wr_i(alloc), .wr_areg_i(disp_areg_i), .wr_preg_i(fl_head_preg),
		.ckpt_i(disp_fire && disp_br_i), .ckpt_tag_i(disp_br_tag_i),
		.restore_i(rob_flush), .restore_tag_i(flush_br_tag),
		.rd_preg_o(map_old_preg)
	);

	redirect_ctrl u_redirect_ctrl (
		.clk, .rst,
		.flush_i(rob_flush), .flush_taken_i(cmpl_taken_i), .redirect_ack_i,
		.busy_o(redir_busy), .redirect_req_o, .redirect_taken_o
	);

	// units are quiet during recovery, only the flushing completion itself overlaps busy
	a_no_cmpl_in_redirect: assert property (@(posedge clk) disable iff (rst)
		cmpl_valid_i |-> !redir_busy || rob_flush);

endmodule

`default_nettype wire

//--- rtl/redirect_ctrl.sv
/*
 * redirect sequencer
 * four-phase req/ack toward fetch after a mispredict,
 * holds dispatch off until the handshake has closed
 */
`default_nettype none

module redirect_ctrl (
	input  wire logic	clk,
	input  wire logic	rst,
	input  wire logic	flush_i,
	input  wire logic	flush_taken_i,
	input  wire logic	redirect_ack_i,
	output logic		busy_o,
	output logic		redirect_req_o,
	output logic		redirect_taken_o
);
	import ooo_ctrl_pkg::*;

	redir_state_t	state_r, state_nxt;
	logic		req_r;
	logic		taken_r;	// resolved direction for fetch

	always_comb begin
		state_nxt = state_r;
		case (state_r)
			RD_IDLE:	if (flush_i) state_nxt = RD_REQ;
			RD_REQ:		if (redirect_ack_i) state_nxt = RD_WAIT_LOW;
			RD_WAIT_LOW:	if (!redirect_ack_i) state_nxt = RD_IDLE;
			default:	state_nxt = RD_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_r <= RD_IDLE;
			req_r <= 1'b0;
			taken_r <= 1'b0;
		end else begin
			state_r <= state_nxt;
			req_r <= (state_nxt == RD_REQ);	// drops on the edge ack is seen
			if (state_r == RD_IDLE && flush_i)
				taken_r <= flush_taken_i;
		end
	end

	// flush cycle blocks too, its dispatch would be squashed
	assign busy_o = flush_i || (state_r != RD_IDLE);
	assign redirect_req_o = req_r;
	assign redirect_taken_o = taken_r;

endmodule

`default_nettype wire

//--- rtl/map_table.sv
/*
 * rename map table
 * current areg to preg mapping with one checkpoint copy per branch tag,
 * saved at branch dispatch and copied back on a mispredict
 */
`default_nettype none
`include "ooo_settings.svh"

module map_table (
	input  wire logic			clk,
	input  wire logic			rst,
	input  wire ooo_types_pkg::areg_t	rd_areg_i,
	input  wire logic			wr_i,
	input  wire ooo_types_pkg::areg_t	wr_areg_i,
	input  wire ooo_types_pkg::preg_t	wr_preg_i,
	input  wire logic			ckpt_i,
	input  wire ooo_types_pkg::br_tag_t	ckpt_tag_i,
	input  wire logic			restore_i,
	input  wire ooo_types_pkg::br_tag_t	restore_tag_i,
	output ooo_types_pkg::preg_t		rd_preg_o
);
	import ooo_types_pkg::*;

	localparam int AREGS = `OOO_AREG_NUM;
	localparam int CKPTS = `OOO_BR_NUM;

	preg_t	map_r	[AREGS];
	preg_t	ckpt_r	[CKPTS][AREGS];	// snapshot per in-flight branch

	// ----------------------------------------
	// lookup, old mapping before this rename
	// ----------------------------------------
	assign rd_preg_o = map_r[rd_areg_i];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < AREGS; r++)
				map_r[r] <= preg_t'(r);	// identity map
		end else if (restore_i) begin
			map_r <= ckpt_r[restore_tag_i];	// back to the state at the branch
		end else if (wr_i) begin
			map_r[wr_areg_i] <= wr_preg_i;
		end
	end

	// branches never rename, so the snapshot is the map as it stands
	always_ff @(posedge clk) begin
		if (ckpt_i)
			ckpt_r[ckpt_tag_i] <= map_r;
	end

endmodule

`default_nettype wire

//--- rtl/free_list.sv
/*
 * free list of physical registers
 * circular FIFO, allocation at the head, returns at the tail,
 * head restore on a mispredict reclaims the younger allocations
 */
`default_nettype none
`include "ooo_settings.svh"

module free_list (
	input  wire logic			clk,
	input  wire logic			rst,
	input  wire logic			alloc_i,
	input  wire logic			free_valid_i,
	input  wire ooo_types_pkg::preg_t	free_preg_i,
	input  wire logic			restore_i,
	input  wire ooo_types_pkg::fl_ptr_t	restore_head_i,
	output logic				empty_o,
	output ooo_types_pkg::preg_t		head_preg_o,
	output ooo_types_pkg::fl_ptr_t		head_ptr_o
);
	import ooo_types_pkg::*;

	localparam int DEPTH = `OOO_FL_DEPTH;
	localparam int IDX_W = $bits(fl_ptr_t) - 1;

	preg_t		mem_r [DEPTH];
	fl_ptr_t	head_r, tail_r;

	assign empty_o = (head_r == tail_r);
	assign head_preg_o = mem_r[head_r[IDX_W-1:0]];	// next register handed out
	assign head_ptr_o = head_r;

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= fl_ptr_t'(DEPTH);	// full, wrap bits differ
			// pregs above the identity map start free, in order
			for (int i = 0; i < DEPTH; i++)
				mem_r[i] <= preg_t'(`OOO_AREG_NUM + i);
		end else begin
			if (restore_i)
				head_r <= restore_head_i;
			else if (alloc_i)
				head_r <= head_r + 1'b1;
			// a retire in the flush cycle still lands
			if (free_valid_i) begin
				mem_r[tail_r[IDX_W-1:0]] <= free_preg_i;
				tail_r <= tail_r + 1'b1;
			end
		end
	end

	a_fl_no_underflow: assert property (@(posedge clk) disable iff (rst)
		alloc_i |-> !empty_o);

endmodule

`default_nettype wire

//--- rtl/rob.sv
/*
 * reorder buffer
 * allocates at the tail, marks done by index, retires done entries in order
 * from the head, and on a branch mispredict rolls the tail back to just
 * after the branch while handing out the saved free-list head and tag
 */
`default_nettype none
`include "ooo_settings.svh"

module rob (
	input  wire logic			clk,
	input  wire logic			rst,
	// dispatch side
	input  wire logic			disp_fire_i,
	input  wire ooo_types_pkg::areg_t	disp_areg_i,
	input  wire ooo_types_pkg::preg_t	disp_preg_i,
	input  wire ooo_types_pkg::preg_t	disp_old_preg_i,
	input  wire logic			disp_br_i,
	input  wire logic			disp_pred_taken_i,
	input  wire ooo_types_pkg::br_tag_t	disp_br_tag_i,
	input  wire ooo_types_pkg::fl_ptr_t	disp_fl_head_i,
	// completion from the functional units
	input  wire logic			cmpl_valid_i,
	input  wire ooo_types_pkg::rob_idx_t	cmpl_rob_idx_i,
	input  wire logic			cmpl_taken_i,
	output logic				full_o,
	output ooo_types_pkg::rob_idx_t		tail_idx_o,
	// retire side
	output logic				retire_valid_o,
	output ooo_types_pkg::areg_t		retire_areg_o,
	output ooo_types_pkg::preg_t		retire_preg_o,
	output ooo_types_pkg::preg_t		retire_old_preg_o,
	output logic				retire_has_dest_o,
	// early recovery
	output logic				flush_o,
	output ooo_types_pkg::fl_ptr_t		flush_fl_head_o,
	output ooo_types_pkg::br_tag_t		flush_br_tag_o
);
	import ooo_types_pkg::*;

	localparam int DEPTH = `OOO_ROB_DEPTH;
	localparam int IDX_W = $bits(rob_idx_t);

	// ----------------------------------------
	// entry payload, written at dispatch only
	// ----------------------------------------
	areg_t		areg_r		[DEPTH];
	preg_t		preg_r		[DEPTH];	// new mapping
	preg_t		old_preg_r	[DEPTH];	// mapping replaced, freed at retire
	logic		br_r		[DEPTH];
	logic		pred_r		[DEPTH];	// predicted direction
	br_tag_t	tag_r		[DEPTH];
	fl_ptr_t	fl_head_r	[DEPTH];	// free-list head when dispatched

	logic [DEPTH-1:0]	done_r;
	rob_ptr_t		head_r, tail_r;
	rob_ptr_t		br_ptr;		// full pointer of the completing entry
	rob_idx_t		head_idx, tail_idx;
	logic			empty;

	assign head_idx = head_r[IDX_W-1:0];
	assign tail_idx = tail_r[IDX_W-1:0];
	assign tail_idx_o = tail_idx;

	assign empty = (head_r == tail_r);
	// same slot, opposite lap
	assign full_o = (head_r[IDX_W] != tail_r[IDX_W]) && (head_idx == tail_idx);

	// ----------------------------------------
	// retire
	// ----------------------------------------
	assign retire_valid_o = !empty && done_r[head_idx];
	assign retire_has_dest_o = !br_r[head_idx];	// branches carry no destination
	assign retire_areg_o = retire_has_dest_o ? areg_r[head_idx] : '0;
	assign retire_preg_o = retire_has_dest_o ? preg_r[head_idx] : '0;
	assign retire_old_preg_o = old_preg_r[head_idx];

	// ----------------------------------------
	// mispredict detection
	// ----------------------------------------
	assign flush_o = cmpl_valid_i && br_r[cmpl_rob_idx_i]
		&& (pred_r[cmpl_rob_idx_i] != cmpl_taken_i);
	assign flush_fl_head_o = fl_head_r[cmpl_rob_idx_i];
	assign flush_br_tag_o = tag_r[cmpl_rob_idx_i];

	// a slot below the head index sits one lap ahead of it
	assign br_ptr = {(cmpl_rob_idx_i >= head_idx) ? head_r[IDX_W] : ~head_r[IDX_W],
		cmpl_rob_idx_i};

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
			done_r <= '0;
		end else begin
			if (retire_valid_o)
				head_r <= head_r + 1'b1;
			if (flush_o)
				tail_r <= br_ptr + 1'b1;	// drop everything younger
			else if (disp_fire_i)
				tail_r <= tail_r + 1'b1;
			if (disp_fire_i)
				done_r[tail_idx] <= 1'b0;	// slot may hold a squashed entry
			if (cmpl_valid_i)
				done_r[cmpl_rob_idx_i] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (disp_fire_i) begin
			areg_r[tail_idx] <= disp_areg_i;
			preg_r[tail_idx] <= disp_preg_i;
			old_preg_r[tail_idx] <= disp_old_preg_i;
			br_r[tail_idx] <= disp_br_i;
			pred_r[tail_idx] <= disp_pred_taken_i;
			tag_r[tail_idx] <= disp_br_tag_i;
			fl_head_r[tail_idx] <= disp_fl_head_i;
		end
	end

	// dispatch ready is formed in the top from full_o
	a_rob_no_overflow: assert property (@(posedge clk) disable iff (rst)
		disp_fire_i |-> !full_o);

endmodule

`default_nettype wire

//--- rtl/ooo_ctrl_pkg.sv
/*
 * control encodings of the rename core
 */
`default_nettype none

package ooo_ctrl_pkg;
	// redirect handshake toward fetch
	typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_WAIT_LOW} redir_state_t;
endpackage

`default_nettype wire

//--- rtl/ooo_types_pkg.sv
/*
 * datapath types of the rename core
 * register numbers, ROB and free-list pointers, branch tags
 */
`default_nettype none
`include "ooo_settings.svh"

package ooo_types_pkg;
	typedef logic [$clog2(`OOO_AREG_NUM)-1:0]	areg_t;		// architectural reg
	typedef logic [$clog2(`OOO_PREG_NUM)-1:0]	preg_t;		// physical reg
	typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0]	rob_idx_t;	// ROB slot
	typedef logic [$clog2(`OOO_ROB_DEPTH):0]	rob_ptr_t;	// slot plus wrap bit
	typedef logic [$clog2(`OOO_FL_DEPTH):0]		fl_ptr_t;	// free-list slot plus wrap
	typedef logic [$clog2(`OOO_BR_NUM)-1:0]		br_tag_t;	// checkpoint tag
endpackage

`default_nettype wire

//--- rtl/ooo_settings.svh
/*
 * size settings for the rename and retire core
 * register counts, ROB depth and number of branch checkpoints
 */
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

`define OOO_AREG_NUM	8	// architectural registers
`define OOO_PREG_NUM	16	// physical registers
`define OOO_ROB_DEPTH	8	// reorder buffer entries
`define OOO_BR_NUM	4	// branch tags, one map checkpoint each

// free list holds every preg not bound to an areg at reset
`define OOO_FL_DEPTH	(`OOO_PREG_NUM - `OOO_AREG_NUM)

`endif
